// File: src.f
+incdir+verilog
+incdir+dv
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
dv/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  --timescale 1ns/1ps \
  --top-module rv_core_tb \
  -f src.f

./obj_dir/Vrv_core_tb

// File: dv/rv_model.svh
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// ------------------------------------------------------------
// instruction-set reference model
// ------------------------------------------------------------

logic [31:0] model_pc;
logic [31:0] model_regs [32];
logic [31:0] model_mem [`RV_DATA_WORDS];

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
  logic [31:0] r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: r = (a < b) ? 32'd1 : 32'd0;
    3'd4: r = a ^ b;
    3'd5: r = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// steps one instruction and returns the store bus values expected after the edge
function automatic void model_step(output logic [31:0] exp_address,
                                   output logic [31:0] exp_data,
                                   output logic [3:0] exp_enable,
                                   output logic exp_write);
  logic [31:0] inst;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] imm_u;
  logic [31:0] next_pc;
  logic [31:0] result;
  logic [31:0] address;
  logic [31:0] word;
  logic [`RV_DATA_ADDR_BITS-1:0] index;
  logic [4:0] rd;
  logic [2:0] f3;
  logic writes;
  logic taken;
  int bytes;
  int lane;
  inst = program_mem[model_pc[11:2]];
  rd = inst[11:7];
  f3 = inst[14:12];
  a = model_regs[inst[19:15]];
  b = model_regs[inst[24:20]];
  imm_i = 32'($signed(inst[31:20]));
  imm_s = 32'($signed({inst[31:25], inst[11:7]}));
  imm_b = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
  imm_j = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
  imm_u = {inst[31:12], 12'h000};
  next_pc = model_pc + 32'd4;
  result = 32'd0;
  writes = 1'b0;
  exp_address = 32'd0;
  exp_data = 32'd0;
  exp_enable = 4'd0;
  exp_write = 1'b0;
  case (inst[6:0])
    rv_pkg::op_lui: begin
      result = imm_u;
      writes = 1'b1;
    end
    rv_pkg::op_auipc: begin
      result = model_pc + imm_u;
      writes = 1'b1;
    end
    rv_pkg::op_jal: begin
      result = model_pc + 32'd4;
      writes = 1'b1;
      next_pc = model_pc + imm_j;
    end
    rv_pkg::op_jalr: begin
      result = model_pc + 32'd4;
      writes = 1'b1;
      next_pc = (a + imm_i) & ~32'd1;
    end
    rv_pkg::op_branch: begin
      case (f3)
        3'd0: taken = (a == b);
        3'd1: taken = (a != b);
        3'd4: taken = ($signed(a) < $signed(b));
        3'd5: taken = ($signed(a) >= $signed(b));
        3'd6: taken = (a < b);
        3'd7: taken = (a >= b);
        default: taken = 1'b0;
      endcase
      if (taken) next_pc = model_pc + imm_b;
    end
    rv_pkg::op_load: begin
      address = a + imm_i;
      index = address[`RV_DATA_ADDR_BITS+1:2];
      word = model_mem[index] >> (8 * address[1:0]);
      case (f3)
        rv_pkg::width_byte:   result = 32'($signed(word[7:0]));
        rv_pkg::width_half:   result = 32'($signed(word[15:0]));
        rv_pkg::width_byte_u: result = {24'd0, word[7:0]};
        rv_pkg::width_half_u: result = {16'd0, word[15:0]};
        default:              result = word;
      endcase
      writes = 1'b1;
    end
    rv_pkg::op_store: begin
      address = a + imm_s;
      index = address[`RV_DATA_ADDR_BITS+1:2];
      bytes = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
      exp_write = 1'b1;
      exp_address = address;
      exp_data = b << (8 * address[1:0]);
      for (int k = 0; k < bytes; k++) begin
        lane = int'(address[1:0]) + k;
        exp_enable[lane] = 1'b1;
        model_mem[index][8*lane +: 8] = b[8*k +: 8];
      end
    end
    rv_pkg::op_alu: begin
      result = alu_ref(f3, inst[30], a, b);
      writes = 1'b1;
    end
    rv_pkg::op_alui: begin
      // only the shift-right form has an alternate encoding
      result = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
      writes = 1'b1;
    end
    default: begin
    end
  endcase
  if (writes && rd != 5'd0) model_regs[rd] = result;
  model_pc = next_pc;
endfunction

// ------------------------------------------------------------
// program builder
// ------------------------------------------------------------

function automatic void emit(input logic [31:0] inst);
  program_mem[prog_len] = inst;
  prog_len++;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

`endif

// File: dv/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core_tb;

  logic        clock;
  logic        reset;
  logic [31:0] inst_data;
  logic [31:0] pc;
  logic [31:0] bus_address;
  logic [31:0] bus_write_data;
  logic [3:0]  bus_byte_enable;
  logic        bus_write_enable;

  logic [31:0] program_mem [1024];
  int          prog_len;
  logic [31:0] halt_pc;
  logic [31:0] lcg_state;

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // random source register among x1..x15
  function automatic logic [4:0] rand_src();
    return 5'(1 + next_random() % 15);
  endfunction

`include "rv_model.svh"

  rv_core rv_core_i (
    .clock            (clock),
    .reset            (reset),
    .inst_data        (inst_data),
    .pc               (pc),
    .bus_address      (bus_address),
    .bus_write_data   (bus_write_data),
    .bus_byte_enable  (bus_byte_enable),
    .bus_write_enable (bus_write_enable)
  );

  // fetch port answers in the same cycle
  assign inst_data = program_mem[pc[11:2]];

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------------------
  // test program
  // ------------------------------------------------------------
  function automatic void build_program();
    logic [31:0] rnd;
    logic [31:0] imm;
    logic [2:0]  f3;
    logic [2:0]  load_f3 [5];
    logic [2:0]  branch_f3 [6];
    logic [4:0]  r1;
    logic [4:0]  r2;
    logic [31:0] lo;
    load_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    branch_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    prog_len = 0;
    for (int i = 0; i < 1024; i++) program_mem[i] = 32'h0000_0013;
    for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
    for (int i = 0; i < `RV_DATA_WORDS; i++) model_mem[i] = 32'd0;
    // base registers x31 = 0x1000 and x30 = 0x2000
    emit({20'h00001, 5'd31, 7'h37});
    emit({20'h00002, 5'd30, 7'h37});
    for (int r = 1; r < 16; r++) begin
      rnd = next_random();
      emit({rnd[31:12], 5'(r), 7'h37});
      emit(enc_i(next_random(), 5'(r), 3'd0, 5'(r), rv_pkg::op_alui));
    end
    // alu ops in blocks of eight with each result stored
    for (int i = 0; i < 40; i++) begin
      rnd = next_random();
      f3 = 3'(i);
      r1 = rand_src();
      r2 = rand_src();
      if (i[3]) begin
        emit(enc_r(((f3 == 3'd0 || f3 == 3'd5) && i[4]) ? 7'h20 : 7'h00,
                   r2, r1, f3, 5'(16 + i % 8)));
      end else begin
        if (f3 == 3'd1 || f3 == 3'd5) imm = {20'd0, (f3 == 3'd5 && i[4]) ? 7'h20 : 7'h00,
                                              rnd[20:16]};
        else imm = {20'd0, rnd[27:16]};
        emit(enc_i(imm, r1, f3, 5'(16 + i % 8), rv_pkg::op_alui));
      end
      emit(enc_s(4 * i, 5'(16 + i % 8), 5'd31, 3'd2));
    end
    // loads and stores of every width
    for (int t = 0; t < 12; t++) begin
      emit(enc_s(4 * t, rand_src(), 5'd30, 3'd2));
      rnd = next_random();
      if (t[0]) emit(enc_s(4 * t + 32'(rnd[17:16]), rand_src(), 5'd30, 3'd0));
      else emit(enc_s(4 * t + 32'({rnd[17], 1'b0}), rand_src(), 5'd30, 3'd1));
      rnd = next_random();
      f3 = load_f3[t % 5];
      if (f3 == 3'd2) lo = 0;
      else if (f3[0]) lo = 32'({rnd[9], 1'b0});
      else lo = 32'(rnd[9:8]);
      emit(enc_i(4 * t + lo, 5'd30, f3, 5'd24, rv_pkg::op_load));
      emit(enc_s(512 + 4 * t, 5'd24, 5'd30, 3'd2));
    end
    // branches on an equal pair and two distinct registers both ways
    for (int j = 0; j < 6; j++) begin
      r1 = rand_src();
      r2 = 5'(r1 % 15 + 1);
      emit(enc_b(8, 5'd5, 5'd5, branch_f3[j]));
      emit(enc_i(1, 5'd25, 3'd0, 5'd25, rv_pkg::op_alui));
      emit(enc_b(8, r2, r1, branch_f3[j]));
      emit(enc_i(1, 5'd25, 3'd0, 5'd25, rv_pkg::op_alui));
      emit(enc_b(8, r1, r2, branch_f3[j]));
      emit(enc_i(1, 5'd25, 3'd0, 5'd25, rv_pkg::op_alui));
    end
    // backward loop of three passes
    emit(enc_i(3, 5'd0, 3'd0, 5'd26, rv_pkg::op_alui));
    emit(enc_i(-1, 5'd26, 3'd0, 5'd26, rv_pkg::op_alui));
    emit(enc_b(-4, 5'd0, 5'd26, 3'd1));
    emit(enc_s(1000, 5'd25, 5'd31, 3'd2));
    // jumps and links
    emit(enc_j(8, 5'd27));
    emit(enc_i(1, 5'd25, 3'd0, 5'd25, rv_pkg::op_alui));
    emit(enc_s(1004, 5'd27, 5'd31, 3'd2));
    rnd = next_random();
    emit({rnd[31:12], 5'd28, 7'h17});
    emit(enc_s(1008, 5'd28, 5'd31, 3'd2));
    emit({20'd0, 5'd29, 7'h17});
    emit(enc_i(16, 5'd29, 3'd0, 5'd29, rv_pkg::op_alui));
    // rd equals rs1 with an odd target offset
    emit(enc_i(1, 5'd29, 3'd0, 5'd29, rv_pkg::op_jalr));
    emit(enc_i(1, 5'd25, 3'd0, 5'd25, rv_pkg::op_alui));
    emit(enc_s(1012, 5'd29, 5'd31, 3'd2));
    emit(enc_j(8, 5'd0));
    emit(enc_i(1, 5'd25, 3'd0, 5'd25, rv_pkg::op_alui));
    emit(enc_i(7, 5'd1, 3'd0, 5'd0, rv_pkg::op_alui));
    emit(enc_s(1016, 5'd0, 5'd31, 3'd2));
    emit(enc_s(1020, 5'd25, 5'd31, 3'd2));
    halt_pc = 32'(prog_len * 4);
    emit(enc_j(0, 5'd0));
  endfunction

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    lcg_state = 32'hc9283165;
    reset = 1'b1;
    build_program();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
  end

  // compare process
  initial begin
    logic [31:0] exp_address;
    logic [31:0] exp_data;
    logic [3:0]  exp_enable;
    logic        exp_write;
    int          cycles;
    cycles = 0;
    do begin
      @(posedge clock);
      #1;
      cycles++;
    end while (reset && cycles < 20);
    if (reset) fail_run("reset was never released");
    check_value("reset pc", `RV_RESET_PC, pc);
    check_value("reset bus address", 32'd0, bus_address);
    check_value("reset bus write data", 32'd0, bus_write_data);
    check_value("reset bus byte enable", 32'd0, {28'd0, bus_byte_enable});
    check_value("reset write enable", 32'd0, {31'd0, bus_write_enable});
    model_pc = `RV_RESET_PC;
    cycles = 0;
    while (model_pc != halt_pc) begin
      @(posedge clock);
      #1;
      model_step(exp_address, exp_data, exp_enable, exp_write);
      check_value("pc", model_pc, pc);
      check_value("bus address", exp_address, bus_address);
      check_value("bus write data", exp_data, bus_write_data);
      check_value("bus byte enable", {28'd0, exp_enable}, {28'd0, bus_byte_enable});
      check_value("bus write enable", {31'd0, exp_write}, {31'd0, bus_write_enable});
      cycles++;
      if (cycles > 2000) fail_run("timeout, program never reached its halt loop");
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_core (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] inst_data,
  output logic [31:0] pc,
  output logic [31:0] bus_address,
  output logic [31:0] bus_write_data,
  output logic [3:0]  bus_byte_enable,
  output logic        bus_write_enable
);

  rv_pkg::opcode_t opcode;
  rv_pkg::alu_op_t alu_op;
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [2:0]      funct3;
  logic [31:0]     imm;
  logic [31:0]     rs1_data;
  logic [31:0]     rs2_data;
  logic [31:0]     alu_b;
  logic [31:0]     alu_result;
  logic [31:0]     load_data;
  logic [31:0]     lane_data;
  logic [3:0]      byte_enable;
  logic            is_load;
  logic            is_store;
  logic            take_branch;
  logic [31:0]     pc_plus4;
  logic [31:0]     pc_plus_imm;
  logic [31:0]     next_pc;
  logic            rd_write;
  logic [31:0]     rd_data;

  rv_decode rv_decode_i (
    .inst_data (inst_data),
    .opcode    (opcode),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .funct3    (funct3),
    .imm       (imm),
    .alu_op    (alu_op)
  );

  rv_regfile rv_regfile_i (
    .clock        (clock),
    .reset        (reset),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .write_enable (rd_write),
    .rd           (rd),
    .rd_data      (rd_data)
  );

  // register form uses rs2 and everything else the immediate
  assign alu_b = (opcode == rv_pkg::op_alu) ? rs2_data : imm;

  rv_alu rv_alu_i (
    .alu_op (alu_op),
    .a      (rs1_data),
    .b      (alu_b),
    .result (alu_result)
  );

  assign is_load  = (opcode == rv_pkg::op_load);
  // no memory writes while held in reset
  assign is_store = (opcode == rv_pkg::op_store) && !reset;

  rv_lsu rv_lsu_i (
    .clock       (clock),
    .address     (alu_result),
    .store_data  (rs2_data),
    .width       (rv_pkg::mem_width_t'(funct3)),
    .load        (is_load),
    .store       (is_store),
    .load_data   (load_data),
    .lane_data   (lane_data),
    .byte_enable (byte_enable)
  );

  // ------------------------------------------------------------
  // branch and next pc
  // ------------------------------------------------------------
  always_comb begin
    case (funct3)
      3'd0:    take_branch = (rs1_data == rs2_data);
      3'd1:    take_branch = (rs1_data != rs2_data);
      3'd4:    take_branch = ($signed(rs1_data) < $signed(rs2_data));
      3'd5:    take_branch = ($signed(rs1_data) >= $signed(rs2_data));
      3'd6:    take_branch = (rs1_data < rs2_data);
      3'd7:    take_branch = (rs1_data >= rs2_data);
      default: take_branch = 1'b0;
    endcase
  end

  assign pc_plus4    = pc + 32'd4;
  assign pc_plus_imm = pc + imm;

  always_comb begin
    if (opcode == rv_pkg::op_jal ||
        (opcode == rv_pkg::op_branch && take_branch)) begin
      next_pc = pc_plus_imm;
    end else if (opcode == rv_pkg::op_jalr) begin
      // alu gives rs1 + imm with bit 0 cleared here
      next_pc = {alu_result[31:1], 1'b0};
    end else begin
      next_pc = pc_plus4;
    end
  end

  // ------------------------------------------------------------
  // writeback
  // ------------------------------------------------------------
  always_comb begin
    rd_write = 1'b1;
    case (opcode)
      rv_pkg::op_alu,
      rv_pkg::op_alui: rd_data = alu_result;
      rv_pkg::op_load: rd_data = load_data;
      rv_pkg::op_jal,
      rv_pkg::op_jalr: rd_data = pc_plus4;
      rv_pkg::op_lui:  rd_data = imm;
      rv_pkg::op_auipc: rd_data = pc_plus_imm;
      default: begin
        rd_write = 1'b0;
        rd_data  = 32'd0;
      end
    endcase
  end

  // pc and the store bus update once per retired instruction
  always_ff @(posedge clock) begin
    if (reset) begin
      pc               <= `RV_RESET_PC;
      bus_address      <= 32'd0;
      bus_write_data   <= 32'd0;
      bus_byte_enable  <= 4'd0;
      bus_write_enable <= 1'b0;
    end else begin
      pc               <= next_pc;
      bus_address      <= is_store ? alu_result : 32'd0;
      bus_write_data   <= is_store ? lane_data : 32'd0;
      bus_byte_enable  <= byte_enable;
      bus_write_enable <= is_store;
    end
  end

endmodule

// File: verilog/rv_lsu.sv
`timescale 1ns/1ps
`include "rv_consts.svh"

module rv_lsu (
  input  logic               clock,
  input  logic [31:0]        address,
  input  logic [31:0]        store_data,
  input  rv_pkg::mem_width_t width,
  input  logic               load,
  input  logic               store,
  output logic [31:0]        load_data,
  output logic [31:0]        lane_data,
  output logic [3:0]         byte_enable
);

  logic [31:0]                   mem [`RV_DATA_WORDS];
  logic [`RV_DATA_ADDR_BITS-1:0] word_index;
  logic [4:0]                    bit_shift;
  logic [31:0]                   read_shifted;
  logic [31:0]                   read_extended;
  logic [3:0]                    lane_mask;

  assign word_index = address[`RV_DATA_ADDR_BITS+1:2];
  assign bit_shift  = {address[1:0], 3'b000};

  // ------------------------------------------------------------
  // load path
  // ------------------------------------------------------------
  assign read_shifted = mem[word_index] >> bit_shift;

  always_comb begin
    case (width)
      rv_pkg::width_byte:   read_extended = {{24{read_shifted[7]}}, read_shifted[7:0]};
      rv_pkg::width_half:   read_extended = {{16{read_shifted[15]}}, read_shifted[15:0]};
      rv_pkg::width_byte_u: read_extended = {24'd0, read_shifted[7:0]};
      rv_pkg::width_half_u: read_extended = {16'd0, read_shifted[15:0]};
      default:              read_extended = read_shifted;
    endcase
  end

  assign load_data = load ? read_extended : 32'd0;

  // ------------------------------------------------------------
  // store path
  // ------------------------------------------------------------
  always_comb begin
    case (width)
      rv_pkg::width_byte: lane_mask = 4'b0001 << address[1:0];
      rv_pkg::width_half: lane_mask = 4'b0011 << address[1:0];
      default:            lane_mask = 4'b1111;
    endcase
  end

  assign lane_data   = store_data << bit_shift;
  assign byte_enable = store ? lane_mask : 4'b0000;

  // merge only the enabled bytes
  always_ff @(posedge clock) begin
    for (int i = 0; i < 4; i++) begin
      if (byte_enable[i]) begin
        mem[word_index][8*i +: 8] <= lane_data[8*i +: 8];
      end
    end
  end

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        write_enable,
  input  logic [4:0]  rd,
  input  logic [31:0] rd_data
);

  // x0 is hardwired to zero and not stored
  logic [31:0] regs [1:31];

  assign rs1_data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (write_enable && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// File: verilog/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_pkg::alu_op_t alu_op,
  input  logic [31:0]     a,
  input  logic [31:0]     b,
  output logic [31:0]     result
);

  logic [4:0] shamt;

  // shift amount is the low five bits of b
  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      rv_pkg::alu_add:  result = a + b;
      rv_pkg::alu_sub:  result = a - b;
      rv_pkg::alu_sll:  result = a << shamt;
      rv_pkg::alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
      rv_pkg::alu_sltu: result = {31'd0, a < b};
      rv_pkg::alu_xor:  result = a ^ b;
      rv_pkg::alu_srl:  result = a >> shamt;
      rv_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);
      rv_pkg::alu_or:   result = a | b;
      rv_pkg::alu_and:  result = a & b;
      default:          result = 32'd0;
    endcase
  end

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  logic [31:0]       inst_data,
  output rv_pkg::opcode_t   opcode,
  output logic [4:0]        rd,
  output logic [4:0]        rs1,
  output logic [4:0]        rs2,
  output logic [2:0]        funct3,
  output logic [31:0]       imm,
  output rv_pkg::alu_op_t   alu_op
);

  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] imm_u;
  logic        funct7_bit5;

  // ------------------------------------------------------------
  // fields
  // ------------------------------------------------------------
  assign opcode      = rv_pkg::opcode_t'(inst_data[6:0]);
  assign rd          = inst_data[11:7];
  assign funct3      = inst_data[14:12];
  assign rs1         = inst_data[19:15];
  assign rs2         = inst_data[24:20];
  assign funct7_bit5 = inst_data[30];

  // immediate formats sign-extended from bit 31
  assign imm_i = {{20{inst_data[31]}}, inst_data[31:20]};
  assign imm_s = {{20{inst_data[31]}}, inst_data[31:25], inst_data[11:7]};
  assign imm_b = {{19{inst_data[31]}}, inst_data[31], inst_data[7],
                  inst_data[30:25], inst_data[11:8], 1'b0};
  assign imm_j = {{11{inst_data[31]}}, inst_data[31], inst_data[19:12],
                  inst_data[20], inst_data[30:21], 1'b0};
  assign imm_u = {inst_data[31:12], 12'd0};

  always_comb begin
    case (opcode)
      rv_pkg::op_alui,
      rv_pkg::op_load,
      rv_pkg::op_jalr:   imm = imm_i;
      rv_pkg::op_store:  imm = imm_s;
      rv_pkg::op_branch: imm = imm_b;
      rv_pkg::op_jal:    imm = imm_j;
      rv_pkg::op_lui,
      rv_pkg::op_auipc:  imm = imm_u;
      default:           imm = 32'd0;
    endcase
  end

  // ------------------------------------------------------------
  // alu operation
  // ------------------------------------------------------------
  always_comb begin
    alu_op = rv_pkg::alu_add;
    if (opcode == rv_pkg::op_alu || opcode == rv_pkg::op_alui) begin
      case (funct3)
        // sub only exists in the register form
        3'd0: alu_op = (opcode == rv_pkg::op_alu && funct7_bit5) ?
                       rv_pkg::alu_sub : rv_pkg::alu_add;
        3'd1: alu_op = rv_pkg::alu_sll;
        3'd2: alu_op = rv_pkg::alu_slt;
        3'd3: alu_op = rv_pkg::alu_sltu;
        3'd4: alu_op = rv_pkg::alu_xor;
        3'd5: alu_op = funct7_bit5 ? rv_pkg::alu_sra : rv_pkg::alu_srl;
        3'd6: alu_op = rv_pkg::alu_or;
        default: alu_op = rv_pkg::alu_and;
      endcase
    end
  end

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

  // major opcodes in instruction bits 6:0
  typedef enum logic [6:0] {
    op_load   = 7'h03,
    op_alui   = 7'h13,
    op_auipc  = 7'h17,
    op_store  = 7'h23,
    op_alu    = 7'h33,
    op_lui    = 7'h37,
    op_branch = 7'h63,
    op_jalr   = 7'h67,
    op_jal    = 7'h6f
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_t;

  // funct3 encodings for loads and stores
  typedef enum logic [2:0] {
    width_byte   = 3'b000,
    width_half   = 3'b001,
    width_word   = 3'b010,
    width_byte_u = 3'b100,
    width_half_u = 3'b101
  } mem_width_t;

endpackage

// File: verilog/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// ------------------------------------------------------------
// memory geometry
// ------------------------------------------------------------

// data memory depth in 32-bit words (128 KiB)
`define RV_DATA_WORDS 32768

// word index width for address bits 16:2
`define RV_DATA_ADDR_BITS 15

// ------------------------------------------------------------
// reset state
// ------------------------------------------------------------

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

`endif
